// File: mem_pkg.sv
package mem_pkg;

  // ----------------------------------------------------------
  // Sizes
  // ----------------------------------------------------------
  localparam int NUM_BANKS   = 4;
  localparam int BANK_WORDS  = 256;
  localparam int ADDR_W      = 32;
  localparam int DATA_W      = 32;
  localparam int STRB_W      = DATA_W / 8;
  localparam int BANK_W      = 2;
  localparam int INDEX_W     = 8;
  localparam int OFFSET_W    = 2;
  localparam int UPPER_W     = ADDR_W - BANK_W - INDEX_W - OFFSET_W;
  localparam int ORDER_DEPTH = 8;
  localparam int PTR_W       = $clog2(ORDER_DEPTH);

  // Bank latency is LAT_MIN plus a 4-bit random draw.
  localparam int LAT_MIN = 2;
  localparam int LAT_W   = 5;

  localparam logic [7:0] LFSR_SEED = 8'hAA;

  localparam logic [1:0] RESP_OKAY   = 2'd0;
  localparam logic [1:0] RESP_SLVERR = 2'd2;

  // Order queue slots in the merger.
  localparam int Q_RD = 0;
  localparam int Q_WR = 1;

  // ----------------------------------------------------------
  // Address decode
  // ----------------------------------------------------------
  typedef struct packed {
    logic [UPPER_W-1:0]  upper;  // Must be zero.
    logic [BANK_W-1:0]   bank;
    logic [INDEX_W-1:0]  index;
    logic [OFFSET_W-1:0] offset; // Byte lane, ignored.
  } mem_addr_fields_t;

  typedef union packed {
    logic [ADDR_W-1:0] raw;
    mem_addr_fields_t  f;
  } mem_addr_u;

  // ----------------------------------------------------------
  // Requests and responses
  // ----------------------------------------------------------
  typedef struct packed {
    mem_addr_u addr;
  } rd_req_t;

  typedef struct packed {
    mem_addr_u         addr;
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
  } wr_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [1:0]        resp;
  } rd_rsp_t;

  typedef struct packed {
    logic [1:0] resp;
  } wr_rsp_t;

  // One entry per issued request, in host issue order.
  typedef struct packed {
    logic              err;
    logic [BANK_W-1:0] bank;
  } order_ent_t;

endpackage

// File: mem_router.sv
`timescale 1ns/1ps

module mem_router
  import mem_pkg::*;
(
  input  logic                  clk,
  input  logic                  rstn,

  input  logic                  ar_valid,
  output logic                  ar_ready,
  input  rd_req_t               ar,

  input  logic                  aw_valid,
  output logic                  aw_ready,
  input  mem_addr_u             aw_addr,

  input  logic                  w_valid,
  output logic                  w_ready,
  input  logic [DATA_W-1:0]     w_data,
  input  logic [STRB_W-1:0]     w_strb,

  output logic [NUM_BANKS-1:0]  rd_req_valid,
  input  logic [NUM_BANKS-1:0]  rd_req_ready,
  output rd_req_t               rd_req [NUM_BANKS],

  output logic [NUM_BANKS-1:0]  wr_req_valid,
  input  logic [NUM_BANKS-1:0]  wr_req_ready,
  output wr_req_t               wr_req [NUM_BANKS],

  output logic                  rd_push,
  output order_ent_t            rd_ent,
  output logic                  wr_push,
  output order_ent_t            wr_ent,

  input  logic                  rd_q_full,
  input  logic                  wr_q_full
);

  // ----------------------------------------------------------
  // Read path, forwarded in the cycle of the host transfer
  // ----------------------------------------------------------
  mem_addr_fields_t ar_f;
  logic             ar_err;

  assign ar_f   = ar.addr.f;
  assign ar_err = |ar_f.upper;

  assign ar_ready = !rd_q_full && (ar_err || rd_req_ready[ar_f.bank]);

  always_comb begin
    for (int i = 0; i < NUM_BANKS; i++) begin
      rd_req_valid[i] = ar_valid && !rd_q_full && !ar_err && (ar_f.bank == BANK_W'(i));
      rd_req[i]       = ar;
    end
  end

  assign rd_push = ar_valid && ar_ready;
  assign rd_ent  = '{err: ar_err, bank: ar_f.bank};

  // ----------------------------------------------------------
  // Write path, address and data joined in holding registers
  // ----------------------------------------------------------
  logic              aw_held;
  logic              w_held;
  mem_addr_u         aw_q;
  logic [DATA_W-1:0] w_data_q;
  logic [STRB_W-1:0] w_strb_q;
  logic              wr_err;
  logic              wr_pend;
  logic              wr_fire;
  logic [BANK_W-1:0] wr_bank;

  assign aw_ready = !aw_held;
  assign w_ready  = !w_held;

  assign wr_bank = aw_q.f.bank;
  assign wr_err  = |aw_q.f.upper;
  assign wr_pend = aw_held && w_held && !wr_q_full;
  assign wr_fire = wr_pend && (wr_err || wr_req_ready[wr_bank]);

  always_ff @(posedge clk) begin
    if (rstn) begin
      aw_held <= 1'b0;
      w_held  <= 1'b0;
    end else begin
      if (aw_valid && aw_ready)
        aw_held <= 1'b1;
      else if (wr_fire)
        aw_held <= 1'b0;
      if (w_valid && w_ready)
        w_held <= 1'b1;
      else if (wr_fire)
        w_held <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (aw_valid && aw_ready)
      aw_q <= aw_addr;
    if (w_valid && w_ready) begin
      w_data_q <= w_data;
      w_strb_q <= w_strb;
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_BANKS; i++) begin
      wr_req_valid[i] = wr_pend && !wr_err && (wr_bank == BANK_W'(i));
      wr_req[i]       = '{addr: aw_q, data: w_data_q, strb: w_strb_q};
    end
  end

  assign wr_push = wr_fire; // Error entries skip the banks.
  assign wr_ent  = '{err: wr_err, bank: wr_bank};

  // Queue depth is tracked in the merger.
  assert property (@(posedge clk) disable iff (rstn) rd_push |-> !rd_q_full)
    else $error("read order entry pushed into a full queue");
  assert property (@(posedge clk) disable iff (rstn) wr_push |-> !wr_q_full)
    else $error("write order entry pushed into a full queue");

endmodule

// File: mem_bank.sv
`timescale 1ns/1ps

module mem_bank
  import mem_pkg::*;
#(
  parameter int BANK_ID = 0
) (
  input  logic    clk,
  input  logic    rstn,

  input  logic    rd_req_valid,
  output logic    rd_req_ready,
  input  rd_req_t rd_req,

  output logic    rd_rsp_valid,
  input  logic    rd_rsp_ready,
  output rd_rsp_t rd_rsp,

  input  logic    wr_req_valid,
  output logic    wr_req_ready,
  input  wr_req_t wr_req,

  output logic    wr_rsp_valid,
  input  logic    wr_rsp_ready,
  output wr_rsp_t wr_rsp
);

  logic [DATA_W-1:0]  mem [BANK_WORDS];

  logic [7:0]         lfsr;
  logic [LAT_W-1:0]   lat_draw;

  logic               rd_busy;
  logic [LAT_W-1:0]   rd_cnt;
  logic [INDEX_W-1:0] rd_idx;
  logic               rd_accept;
  logic               rd_done;

  logic               wr_busy;
  logic [LAT_W-1:0]   wr_cnt;
  logic [INDEX_W-1:0] wr_idx;
  logic [DATA_W-1:0]  wr_data_q;
  logic [STRB_W-1:0]  wr_strb_q;
  logic               wr_accept;
  logic               wr_done;

  // ----------------------------------------------------------
  // Latency source
  // ----------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rstn)
      lfsr <= LFSR_SEED ^ 8'(BANK_ID * 29); // Distinct per bank, never zero.
    else
      lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
  end

  assign lat_draw = LAT_W'(LAT_MIN) + LAT_W'(lfsr[3:0]);

  // ----------------------------------------------------------
  // Read engine
  // ----------------------------------------------------------
  assign rd_req_ready = !rd_busy;
  assign rd_accept    = rd_req_valid && rd_req_ready;
  assign rd_done      = rd_busy && !rd_rsp_valid && (rd_cnt == LAT_W'(1));

  always_ff @(posedge clk) begin
    if (rstn) begin
      rd_busy      <= 1'b0;
      rd_cnt       <= '0;
      rd_rsp_valid <= 1'b0;
    end else begin
      if (rd_accept) begin
        rd_busy <= 1'b1;
        rd_cnt  <= lat_draw;
      end else if (rd_busy && !rd_rsp_valid) begin
        rd_cnt <= rd_cnt - 1'b1;
      end
      if (rd_done) begin
        rd_rsp_valid <= 1'b1;
      end else if (rd_rsp_valid && rd_rsp_ready) begin
        rd_rsp_valid <= 1'b0;
        rd_busy      <= 1'b0; // Free only once the host took it.
      end
    end
  end

  // ----------------------------------------------------------
  // Write engine
  // ----------------------------------------------------------
  assign wr_req_ready = !wr_busy;
  assign wr_accept    = wr_req_valid && wr_req_ready;
  assign wr_done      = wr_busy && !wr_rsp_valid && (wr_cnt == LAT_W'(1));

  always_ff @(posedge clk) begin
    if (rstn) begin
      wr_busy      <= 1'b0;
      wr_cnt       <= '0;
      wr_rsp_valid <= 1'b0;
    end else begin
      if (wr_accept) begin
        wr_busy <= 1'b1;
        wr_cnt  <= lat_draw;
      end else if (wr_busy && !wr_rsp_valid) begin
        wr_cnt <= wr_cnt - 1'b1;
      end
      if (wr_done) begin
        wr_rsp_valid <= 1'b1;
      end else if (wr_rsp_valid && wr_rsp_ready) begin
        wr_rsp_valid <= 1'b0;
        wr_busy      <= 1'b0;
      end
    end
  end

  // Request payload and the storage array.
  always_ff @(posedge clk) begin
    if (rd_accept)
      rd_idx <= rd_req.addr.f.index;
    if (wr_accept) begin
      wr_idx    <= wr_req.addr.f.index;
      wr_data_q <= wr_req.data;
      wr_strb_q <= wr_req.strb;
    end
    if (rd_done)
      rd_rsp <= '{data: mem[rd_idx], resp: RESP_OKAY}; // Sampled at the end.
    if (wr_done) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (wr_strb_q[b])
          mem[wr_idx][b*8 +: 8] <= wr_data_q[b*8 +: 8];
      end
      wr_rsp <= '{resp: RESP_OKAY};
    end
  end

  assert property (@(posedge clk) disable iff (rstn)
    rd_rsp_valid && !rd_rsp_ready |=> rd_rsp_valid && $stable(rd_rsp))
    else $error("read response changed while stalled");
  assert property (@(posedge clk) disable iff (rstn)
    wr_rsp_valid && !wr_rsp_ready |=> wr_rsp_valid && $stable(wr_rsp))
    else $error("write response changed while stalled");
  assert property (@(posedge clk) disable iff (rstn) rd_accept |-> !rd_rsp_valid)
    else $error("read accepted while a response is pending");
  assert property (@(posedge clk) disable iff (rstn) wr_accept |-> !wr_rsp_valid)
    else $error("write accepted while a response is pending");

endmodule

// File: mem_resp_merge.sv
`timescale 1ns/1ps

module mem_resp_merge
  import mem_pkg::*;
(
  input  logic                 clk,
  input  logic                 rstn,

  input  logic                 rd_push,
  input  order_ent_t           rd_ent,
  input  logic                 wr_push,
  input  order_ent_t           wr_ent,

  output logic                 rd_q_full,
  output logic                 wr_q_full,

  input  logic [NUM_BANKS-1:0] rd_rsp_valid,
  output logic [NUM_BANKS-1:0] rd_rsp_ready,
  input  rd_rsp_t              rd_rsp [NUM_BANKS],

  input  logic [NUM_BANKS-1:0] wr_rsp_valid,
  output logic [NUM_BANKS-1:0] wr_rsp_ready,
  input  wr_rsp_t              wr_rsp [NUM_BANKS],

  output logic                 r_valid,
  input  logic                 r_ready,
  output rd_rsp_t              r,

  output logic                 b_valid,
  input  logic                 b_ready,
  output wr_rsp_t              b
);

  // ----------------------------------------------------------
  // Order queues, slot Q_RD for reads and Q_WR for writes
  // ----------------------------------------------------------
  order_ent_t       q_mem [2][ORDER_DEPTH];
  logic [PTR_W-1:0] wptr  [2];
  logic [PTR_W-1:0] rptr  [2];
  logic [PTR_W:0]   count [2];
  logic [1:0]       push;
  logic [1:0]       pop;
  logic [1:0]       busy;
  order_ent_t       push_ent [2];
  order_ent_t       rd_head;
  order_ent_t       wr_head;

  assign push           = {wr_push, rd_push};
  assign push_ent[Q_RD] = rd_ent;
  assign push_ent[Q_WR] = wr_ent;
  assign pop            = {b_valid && b_ready, r_valid && r_ready};

  always_ff @(posedge clk) begin
    if (rstn) begin
      for (int q = 0; q < 2; q++) begin
        wptr[q]  <= '0;
        rptr[q]  <= '0;
        count[q] <= '0;
      end
    end else begin
      for (int q = 0; q < 2; q++) begin
        if (push[q])
          wptr[q] <= wptr[q] + 1'b1;
        if (pop[q])
          rptr[q] <= rptr[q] + 1'b1;
        count[q] <= count[q] + (PTR_W+1)'(push[q]) - (PTR_W+1)'(pop[q]);
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int q = 0; q < 2; q++) begin
      if (push[q])
        q_mem[q][wptr[q]] <= push_ent[q];
    end
  end

  assign busy[Q_RD] = count[Q_RD] != '0;
  assign busy[Q_WR] = count[Q_WR] != '0;
  assign rd_q_full  = count[Q_RD] == (PTR_W+1)'(ORDER_DEPTH);
  assign wr_q_full  = count[Q_WR] == (PTR_W+1)'(ORDER_DEPTH);
  assign rd_head    = q_mem[Q_RD][rptr[Q_RD]];
  assign wr_head    = q_mem[Q_WR][rptr[Q_WR]];

  // ----------------------------------------------------------
  // Host side, head entry picks the source
  // ----------------------------------------------------------
  assign r_valid = busy[Q_RD] && (rd_head.err || rd_rsp_valid[rd_head.bank]);
  assign r       = rd_head.err ? '{data: '0, resp: RESP_SLVERR} : rd_rsp[rd_head.bank];

  assign b_valid = busy[Q_WR] && (wr_head.err || wr_rsp_valid[wr_head.bank]);
  assign b       = wr_head.err ? '{resp: RESP_SLVERR} : wr_rsp[wr_head.bank];

  // Only the bank at the head sees the host ready.
  always_comb begin
    for (int i = 0; i < NUM_BANKS; i++) begin
      rd_rsp_ready[i] = busy[Q_RD] && !rd_head.err && (rd_head.bank == BANK_W'(i)) && r_ready;
      wr_rsp_ready[i] = busy[Q_WR] && !wr_head.err && (wr_head.bank == BANK_W'(i)) && b_ready;
    end
  end

  assert property (@(posedge clk) disable iff (rstn) pop[Q_RD] |-> busy[Q_RD])
    else $error("read order queue popped while empty");
  assert property (@(posedge clk) disable iff (rstn) pop[Q_WR] |-> busy[Q_WR])
    else $error("write order queue popped while empty");

endmodule

// File: mem_subsys.sv
`timescale 1ns/1ps

module mem_subsys
  import mem_pkg::*;
(
  input  logic              clk,
  input  logic              rstn,

  input  logic              ar_valid,
  output logic              ar_ready,
  input  rd_req_t           ar,

  input  logic              aw_valid,
  output logic              aw_ready,
  input  mem_addr_u         aw_addr,

  input  logic              w_valid,
  output logic              w_ready,
  input  logic [DATA_W-1:0] w_data,
  input  logic [STRB_W-1:0] w_strb,

  output logic              r_valid,
  input  logic              r_ready,
  output rd_rsp_t           r,

  output logic              b_valid,
  input  logic              b_ready,
  output wr_rsp_t           b
);

  logic [NUM_BANKS-1:0] rd_req_valid;
  logic [NUM_BANKS-1:0] rd_req_ready;
  rd_req_t              rd_req [NUM_BANKS];
  logic [NUM_BANKS-1:0] wr_req_valid;
  logic [NUM_BANKS-1:0] wr_req_ready;
  wr_req_t              wr_req [NUM_BANKS];

  logic [NUM_BANKS-1:0] rd_rsp_valid;
  logic [NUM_BANKS-1:0] rd_rsp_ready;
  rd_rsp_t              rd_rsp [NUM_BANKS];
  logic [NUM_BANKS-1:0] wr_rsp_valid;
  logic [NUM_BANKS-1:0] wr_rsp_ready;
  wr_rsp_t              wr_rsp [NUM_BANKS];

  logic                 rd_push;
  order_ent_t           rd_ent;
  logic                 wr_push;
  order_ent_t           wr_ent;
  logic                 rd_q_full;
  logic                 wr_q_full;

  mem_router i_router (
    .clk          (clk),
    .rstn         (rstn),
    .ar_valid     (ar_valid),
    .ar_ready     (ar_ready),
    .ar           (ar),
    .aw_valid     (aw_valid),
    .aw_ready     (aw_ready),
    .aw_addr      (aw_addr),
    .w_valid      (w_valid),
    .w_ready      (w_ready),
    .w_data       (w_data),
    .w_strb       (w_strb),
    .rd_req_valid (rd_req_valid),
    .rd_req_ready (rd_req_ready),
    .rd_req       (rd_req),
    .wr_req_valid (wr_req_valid),
    .wr_req_ready (wr_req_ready),
    .wr_req       (wr_req),
    .rd_push      (rd_push),
    .rd_ent       (rd_ent),
    .wr_push      (wr_push),
    .wr_ent       (wr_ent),
    .rd_q_full    (rd_q_full),
    .wr_q_full    (wr_q_full)
  );

  // ----------------------------------------------------------
  // Banks
  // ----------------------------------------------------------
  for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
    mem_bank #(
      .BANK_ID (i)
    ) i_bank (
      .clk          (clk),
      .rstn         (rstn),
      .rd_req_valid (rd_req_valid[i]),
      .rd_req_ready (rd_req_ready[i]),
      .rd_req       (rd_req[i]),
      .rd_rsp_valid (rd_rsp_valid[i]),
      .rd_rsp_ready (rd_rsp_ready[i]),
      .rd_rsp       (rd_rsp[i]),
      .wr_req_valid (wr_req_valid[i]),
      .wr_req_ready (wr_req_ready[i]),
      .wr_req       (wr_req[i]),
      .wr_rsp_valid (wr_rsp_valid[i]),
      .wr_rsp_ready (wr_rsp_ready[i]),
      .wr_rsp       (wr_rsp[i])
    );
  end

  mem_resp_merge i_merge (
    .clk          (clk),
    .rstn         (rstn),
    .rd_push      (rd_push),
    .rd_ent       (rd_ent),
    .wr_push      (wr_push),
    .wr_ent       (wr_ent),
    .rd_q_full    (rd_q_full),
    .wr_q_full    (wr_q_full),
    .rd_rsp_valid (rd_rsp_valid),
    .rd_rsp_ready (rd_rsp_ready),
    .rd_rsp       (rd_rsp),
    .wr_rsp_valid (wr_rsp_valid),
    .wr_rsp_ready (wr_rsp_ready),
    .wr_rsp       (wr_rsp),
    .r_valid      (r_valid),
    .r_ready      (r_ready),
    .r            (r),
    .b_valid      (b_valid),
    .b_ready      (b_ready),
    .b            (b)
  );

endmodule

// File: tb_mem_subsys.sv
`timescale 1ns/1ps

module tb_mem_subsys
  import mem_pkg::*;
();

  localparam int NUM_OPS = 2000;
  localparam int TIMEOUT = 500;
  localparam int WORDS   = NUM_BANKS * BANK_WORDS;

  logic              clk = 1'b0;
  logic              rstn;
  logic              ar_valid;
  logic              ar_ready;
  rd_req_t           ar;
  logic              aw_valid;
  logic              aw_ready;
  mem_addr_u         aw_addr;
  logic              w_valid;
  logic              w_ready;
  logic [DATA_W-1:0] w_data;
  logic [STRB_W-1:0] w_strb;
  logic              r_valid;
  logic              r_ready;
  rd_rsp_t           r;
  logic              b_valid;
  logic              b_ready;
  wr_rsp_t           b;

  // Reference model, indexed by bank and word.
  logic [DATA_W-1:0] model_mem [WORDS];
  bit                written [WORDS];
  int                rd_pend [WORDS];
  int                wr_pend [WORDS];

  rd_rsp_t     exp_rd [$];
  int          exp_rd_key [$]; // -1 for an out of range access.
  wr_rsp_t     exp_wr [$];
  int          exp_wr_key [$];
  logic [31:0] req_rng = 32'd30657;
  logic [31:0] rsp_rng = ~32'd30657;
  bit          running = 1'b0;
  bit          r_stalled = 1'b0;
  bit          b_stalled = 1'b0;
  rd_rsp_t     r_held;
  wr_rsp_t     b_held;

  mem_subsys i_mem_subsys (
    .clk      (clk),
    .rstn     (rstn),
    .ar_valid (ar_valid),
    .ar_ready (ar_ready),
    .ar       (ar),
    .aw_valid (aw_valid),
    .aw_ready (aw_ready),
    .aw_addr  (aw_addr),
    .w_valid  (w_valid),
    .w_ready  (w_ready),
    .w_data   (w_data),
    .w_strb   (w_strb),
    .r_valid  (r_valid),
    .r_ready  (r_ready),
    .r        (r),
    .b_valid  (b_valid),
    .b_ready  (b_ready),
    .b        (b)
  );

  initial begin
    forever #5 clk = ~clk;
  end

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int word_key(input mem_addr_u a);
    return int'(a.f.bank) * BANK_WORDS + int'(a.f.index);
  endfunction

  function automatic mem_addr_u pick_addr(input logic [31:0] rnd);
    mem_addr_u a;
    a.raw      = '0;
    a.f.bank   = rnd[1:0];
    a.f.index  = {4'h0, rnd[5:2]}; // Small working set so reads hit written words.
    a.f.offset = rnd[7:6];
    if (rnd[11:8] == 4'h0)
      a.f.upper = {rnd[31:13], 1'b1}; // Out of range.
    return a;
  endfunction

  task automatic report_fail(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_rd_rsp(input string name, input rd_rsp_t got, input rd_rsp_t exp);
    if (got.resp !== exp.resp)
      report_fail($sformatf("FAIL t=%0t %s.resp got %0d expected %0d",
                            $time, name, got.resp, exp.resp));
    else if (exp.resp == RESP_OKAY && got.data !== exp.data)
      report_fail($sformatf("FAIL t=%0t %s.data got %08h expected %08h",
                            $time, name, got.data, exp.data));
  endtask

  task automatic check_wr_rsp(input string name, input wr_rsp_t got, input wr_rsp_t exp);
    if (got.resp !== exp.resp)
      report_fail($sformatf("FAIL t=%0t %s.resp got %0d expected %0d",
                            $time, name, got.resp, exp.resp));
  endtask

  // ----------------------------------------------------------
  // Response side
  // ----------------------------------------------------------
  task automatic watch_read();
    rd_rsp_t exp;
    int      key;
    if (r_stalled) begin
      if (r_valid !== 1'b1)
        report_fail("r_valid dropped before the host took the response");
      check_rd_rsp("r held", r, r_held);
    end
    r_stalled = r_valid && !r_ready;
    r_held    = r;
    if (r_valid && r_ready) begin
      if (exp_rd.size() == 0)
        report_fail("read response arrived with no read outstanding");
      exp = exp_rd.pop_front();
      key = exp_rd_key.pop_front();
      check_rd_rsp("r", r, exp);
      if (key >= 0)
        rd_pend[key]--;
    end
  endtask

  task automatic watch_write();
    wr_rsp_t exp;
    int      key;
    if (b_stalled) begin
      if (b_valid !== 1'b1)
        report_fail("b_valid dropped before the host took the response");
      check_wr_rsp("b held", b, b_held);
    end
    b_stalled = b_valid && !b_ready;
    b_held    = b;
    if (b_valid && b_ready) begin
      if (exp_wr.size() == 0)
        report_fail("write response arrived with no write outstanding");
      exp = exp_wr.pop_front();
      key = exp_wr_key.pop_front();
      check_wr_rsp("b", b, exp);
      if (key >= 0)
        wr_pend[key]--;
    end
  endtask

  // Ready drives on the falling edge, sampling just after.
  always @(negedge clk) begin
    rsp_rng = xorshift32(rsp_rng);
    r_ready = rsp_rng[1:0] != 2'b00;
    b_ready = rsp_rng[3:2] != 2'b00;
    #1;
    if (running) begin
      watch_read();
      watch_write();
    end
  end

  // ----------------------------------------------------------
  // Request side
  // ----------------------------------------------------------
  task automatic send_read(input mem_addr_u a);
    bit done;
    int n;
    int key;
    done = 1'b0;
    n    = 0;
    while (!done) begin
      if (n == TIMEOUT)
        report_fail("timed out waiting for ar_ready");
      ar_valid = 1'b1;
      ar       = '{addr: a};
      aw_valid = 1'b0;
      w_valid  = 1'b0;
      #1;
      done = ar_ready;
      n++;
      @(negedge clk);
    end
    if (a.f.upper != '0) begin
      exp_rd.push_back('{data: '0, resp: RESP_SLVERR});
      exp_rd_key.push_back(-1);
    end else begin
      key = word_key(a);
      exp_rd.push_back('{data: model_mem[key], resp: RESP_OKAY});
      exp_rd_key.push_back(key);
      rd_pend[key]++;
    end
  endtask

  task automatic send_write(input mem_addr_u a, input logic [DATA_W-1:0] data,
                            input logic [STRB_W-1:0] strb, input int aw_delay,
                            input int w_delay);
    bit aw_done;
    bit w_done;
    int n;
    int key;
    aw_done = 1'b0;
    w_done  = 1'b0;
    n       = 0;
    while (!(aw_done && w_done)) begin
      if (n == TIMEOUT)
        report_fail("timed out waiting for aw_ready or w_ready");
      ar_valid = 1'b0;
      aw_valid = !aw_done && n >= aw_delay;
      aw_addr  = a;
      w_valid  = !w_done && n >= w_delay;
      w_data   = data;
      w_strb   = strb;
      #1;
      if (aw_valid && aw_ready)
        aw_done = 1'b1;
      if (w_valid && w_ready)
        w_done = 1'b1;
      n++;
      @(negedge clk);
    end
    if (a.f.upper != '0) begin
      exp_wr.push_back('{resp: RESP_SLVERR}); // Model left untouched.
      exp_wr_key.push_back(-1);
    end else begin
      key = word_key(a);
      for (int i = 0; i < STRB_W; i++) begin
        if (strb[i])
          model_mem[key][i*8 +: 8] = data[i*8 +: 8];
      end
      written[key] = 1'b1;
      wr_pend[key]++;
      exp_wr.push_back('{resp: RESP_OKAY});
      exp_wr_key.push_back(key);
    end
  endtask

  initial begin
    mem_addr_u         a;
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              is_read;
    logic              fresh;
    int                key;
    int                gap;
    int                n;
    rstn     = 1'b1;
    ar_valid = 1'b0;
    ar       = '0;
    aw_valid = 1'b0;
    aw_addr  = '0;
    w_valid  = 1'b0;
    w_data   = '0;
    w_strb   = '0;
    r_ready  = 1'b0;
    b_ready  = 1'b0;
    for (int c = 0; c < 3; c++) begin
      @(negedge clk);
      if (r_valid !== 1'b0 || b_valid !== 1'b0)
        report_fail("r_valid or b_valid high during reset");
    end
    rstn = 1'b0;
    @(negedge clk);
    if (r_valid !== 1'b0 || b_valid !== 1'b0)
      report_fail("r_valid or b_valid high in the first cycle after reset");
    running = 1'b1;

    for (int i = 0; i < NUM_OPS; i++) begin
      req_rng = xorshift32(req_rng);
      a       = pick_addr(req_rng);
      req_rng = xorshift32(req_rng);
      is_read = req_rng[0];
      key     = word_key(a);
      fresh   = 1'b0;
      // Keep a read and a write to the same word from overlapping.
      if (a.f.upper == '0) begin
        if (is_read && (!written[key] || wr_pend[key] != 0))
          is_read = 1'b0;
        else if (!is_read && rd_pend[key] != 0)
          is_read = 1'b1;
        fresh = !written[key];
      end
      if (is_read) begin
        send_read(a);
      end else begin
        gap     = int'(req_rng[3:2]) + 1;
        data    = xorshift32(req_rng ^ 32'h5a5a_0f0f);
        strb    = fresh ? '1 : req_rng[7:4]; // First write fills the whole word.
        case (req_rng[9:8])
          2'd2:    send_write(a, data, strb, 0, gap);
          2'd3:    send_write(a, data, strb, gap, 0);
          default: send_write(a, data, strb, 0, 0);
        endcase
      end
    end
    ar_valid = 1'b0;
    aw_valid = 1'b0;
    w_valid  = 1'b0;

    n = 0;
    while ((exp_rd.size() != 0 || exp_wr.size() != 0) && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (exp_rd.size() == 0 && exp_wr.size() == 0) begin
      $display("Test passed");
      $finish;
    end else begin
      report_fail("responses still outstanding after the drain timeout");
    end
  end

endmodule

// File: filelist.f
mem_pkg.sv
mem_router.sv
mem_bank.sv
mem_resp_merge.sv
mem_subsys.sv
tb_mem_subsys.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mem_subsys
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Test passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
